/* design/accCore.sv */
`timescale 1ns/10ps

module accCore import accPkg::*; (
	input  logic                  clr,
	input  logic                  rst,
	output logic [addrWidth-1:0]  progAddr,
	input  logic [instrWidth-1:0] progData,
	output logic                  wbCyc,
	output logic                  wbStb,
	output logic                  wbWe,
	output logic [addrWidth-1:0]  wbAdr,
	output logic [dataWidth-1:0]  wbDatO,
	input  logic [dataWidth-1:0]  wbDatI,
	input  logic                  wbAck,
	output logic                  halted,
	output logic                  retireValid,
	output logic                  retireAcc,
	output logic [dataWidth-1:0]  retireData
);

	// Issue register between fetch and execute, and the write port into the accumulators.
	issueIf  issueBus ();
	resultIf resBus ();

	////////////////////////////////////////////////////////////////////////////
	// Stages
	////////////////////////////////////////////////////////////////////////////

	fetchDecode fetchDecode_i (
		.clr      (clr),
		.rst      (rst),
		.progAddr (progAddr),
		.progData (progData),
		.halted   (halted),
		.issue    (issueBus.source)
	);

	// Execute also owns the data bus and the halt flag.
	executeStage executeStage_i (
		.clr    (clr),
		.rst    (rst),
		.issue  (issueBus.sink),
		.res    (resBus.source),
		.wbCyc  (wbCyc),
		.wbStb  (wbStb),
		.wbWe   (wbWe),
		.wbAdr  (wbAdr),
		.wbDatO (wbDatO),
		.wbDatI (wbDatI),
		.wbAck  (wbAck),
		.halted (halted)
	);

	resultStage resultStage_i (
		.clr         (clr),
		.rst         (rst),
		.res         (resBus.sink),
		.retireValid (retireValid),
		.retireAcc   (retireAcc),
		.retireData  (retireData)
	);

endmodule

/* design/accIf.sv */
`timescale 1ns/10ps

////////////////////////////////////////////////////////////////////////////
// Issue register, from fetch/decode into execute
////////////////////////////////////////////////////////////////////////////

interface issueIf import accPkg::*; ();

	// Forward payload, held by fetch while stall is high.
	logic       valid;
	instrWord_u instr;
	opClass_e   opClass;

	// Control sent back by execute.
	logic                 stall;
	logic                 flush;
	logic [addrWidth-1:0] flushTarget;

	modport source (
		output valid, instr, opClass,
		input  stall, flush, flushTarget
	);

	modport sink (
		input  valid, instr, opClass,
		output stall, flush, flushTarget
	);

endinterface

////////////////////////////////////////////////////////////////////////////
// Accumulator write port, from execute into the result stage
////////////////////////////////////////////////////////////////////////////

interface resultIf import accPkg::*; ();

	// A write lands at the edge where wrEn is high.
	logic                 wrEn;
	logic                 wrAcc;
	logic [dataWidth-1:0] wrData;

	// Current accumulator contents, read back by execute.
	logic [dataWidth-1:0] accA;
	logic [dataWidth-1:0] accB;

	modport source (
		output wrEn, wrAcc, wrData,
		input  accA, accB
	);

	modport sink (
		input  wrEn, wrAcc, wrData,
		output accA, accB
	);

endinterface

/* design/accPkg.sv */
package accPkg;

	////////////////////////////////////////////////////////////////////////////
	// Widths
	////////////////////////////////////////////////////////////////////////////

	// Accumulators and data memory bytes are both eight bits wide.
	localparam int dataWidth = 8;

	// The program counter and data addresses share one 8-bit space each.
	localparam int addrWidth = 8;

	// Every instruction is a single 16-bit word.
	localparam int instrWidth = 16;

	////////////////////////////////////////////////////////////////////////////
	// Opcodes and operation classes
	////////////////////////////////////////////////////////////////////////////

	// Codes 12 to 14 are not defined and behave as NOP.
	typedef enum logic [3:0] {
		NOP  = 4'd0,
		LDI  = 4'd1,
		ADD  = 4'd2,
		SUB  = 4'd3,
		AND  = 4'd4,
		OR   = 4'd5,
		XOR  = 4'd6,
		LD   = 4'd7,
		ST   = 4'd8,
		JMP  = 4'd9,
		BZ   = 4'd10,
		BNZ  = 4'd11,
		HALT = 4'd15
	} opcode_e;

	// The class is worked out at fetch so that execute only has to look at three bits.
	typedef enum logic [2:0] {
		aluOp,
		loadOp,
		storeOp,
		jumpOp,
		branchOp,
		haltOp,
		nopOp
	} opClass_e;

	////////////////////////////////////////////////////////////////////////////
	// Instruction word
	////////////////////////////////////////////////////////////////////////////

	// ALU form. With useAcc set, the second operand is the other accumulator.
	typedef struct packed {
		opcode_e              opcode;
		logic                 accSel;
		logic                 useAcc;
		logic [1:0]           pad;
		logic [dataWidth-1:0] imm;
	} aluForm_s;

	// Address form, used by the loads, the stores and all branches.
	typedef struct packed {
		opcode_e              opcode;
		logic                 accSel;
		logic [2:0]           pad;
		logic [addrWidth-1:0] target;
	} addrForm_s;

	// The opcode and accSel sit in the same bits in both forms.
	typedef union packed {
		aluForm_s  aluForm;
		addrForm_s addrForm;
	} instrWord_u;

endpackage

/* design/executeStage.sv */
`timescale 1ns/10ps

module executeStage import accPkg::*; (
	input  logic                 clr,
	input  logic                 rst,
	issueIf.sink                 issue,
	resultIf.source              res,
	output logic                 wbCyc,
	output logic                 wbStb,
	output logic                 wbWe,
	output logic [addrWidth-1:0] wbAdr,
	output logic [dataWidth-1:0] wbDatO,
	input  logic [dataWidth-1:0] wbDatI,
	input  logic                 wbAck,
	output logic                 halted
);

	// Fields of the item in execute, read through both views of the word.
	opcode_e              opcode;
	logic                 accSel;
	logic [addrWidth-1:0] target;

	// Selected accumulator, the other one, and the resolved ALU operand.
	logic [dataWidth-1:0] selAcc;
	logic [dataWidth-1:0] otherAcc;
	logic [dataWidth-1:0] operand;
	logic [dataWidth-1:0] aluResult;

	// Memory operation of either direction.
	logic isMem;

	// Access in progress. It also drives wbCyc.
	logic busy;

	// The access finishes in this cycle.
	logic memDone;

	assign opcode = issue.instr.aluForm.opcode;
	assign accSel = issue.instr.aluForm.accSel;
	assign target = issue.instr.addrForm.target;

	assign selAcc   = accSel ? res.accB : res.accA;
	assign otherAcc = accSel ? res.accA : res.accB;
	assign operand  = issue.instr.aluForm.useAcc ? otherAcc : issue.instr.aluForm.imm;

	////////////////////////////////////////////////////////////////////////////
	// ALU
	////////////////////////////////////////////////////////////////////////////

	// All results wrap at eight bits.
	always_comb begin
		case (opcode)
			ADD:     aluResult = selAcc + operand;
			SUB:     aluResult = selAcc - operand;
			AND:     aluResult = selAcc & operand;
			OR:      aluResult = selAcc | operand;
			XOR:     aluResult = selAcc ^ operand;
			default: aluResult = operand;
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// Branches
	////////////////////////////////////////////////////////////////////////////

	// BZ and BNZ test the selected accumulator. JMP is always taken.
	always_comb begin
		issue.flush = 1'b0;
		if (issue.valid) begin
			if (issue.opClass == jumpOp) begin
				issue.flush = 1'b1;
			end else if (issue.opClass == branchOp) begin
				issue.flush = (opcode == BZ) ? (selAcc == '0) : (selAcc != '0);
			end
		end
	end

	assign issue.flushTarget = target;

	////////////////////////////////////////////////////////////////////////////
	// Wishbone classic master
	////////////////////////////////////////////////////////////////////////////

	assign isMem   = issue.valid && (issue.opClass == loadOp || issue.opClass == storeOp);
	assign memDone = busy && wbAck;

	// The pipeline is held from the first cycle the access is seen until the ack.
	assign issue.stall = isMem && !memDone;

	// Address, direction and store data are captured when the access starts
	// and stay put until the ack edge.
	always_ff @(posedge clr) begin
		if (rst) begin
			busy  <= 1'b0;
			wbStb <= 1'b0;
			wbWe  <= 1'b0;
		end else if (isMem && !busy) begin
			busy  <= 1'b1;
			wbStb <= 1'b1;
			wbWe  <= (issue.opClass == storeOp);
		end else if (memDone) begin
			busy  <= 1'b0;
			wbStb <= 1'b0;
			wbWe  <= 1'b0;
		end
	end

	always_ff @(posedge clr) begin
		if (isMem && !busy) begin
			wbAdr  <= target;
			wbDatO <= selAcc;
		end
	end

	assign wbCyc = busy;

	////////////////////////////////////////////////////////////////////////////
	// Accumulator write and halt
	////////////////////////////////////////////////////////////////////////////

	// ALU results land at the end of their only cycle. A load lands on the ack edge.
	assign res.wrEn   = (issue.valid && issue.opClass == aluOp) ||
	                    (memDone && issue.opClass == loadOp);
	assign res.wrAcc  = accSel;
	assign res.wrData = (issue.opClass == loadOp) ? wbDatI : aluResult;

	always_ff @(posedge clr) begin
		if (rst) begin
			halted <= 1'b0;
		end else if (issue.valid && issue.opClass == haltOp) begin
			halted <= 1'b1;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////////////////////

	// A strobe outside of a cycle is not legal Wishbone.
	stbInCyc: assert property (
		@(posedge clr) disable iff (rst)
		wbStb |-> wbCyc
	) else $error("wbStb high without wbCyc");

	// The slave may sample at any point up to its ack.
	busHeld: assert property (
		@(posedge clr) disable iff (rst)
		wbStb && !wbAck |=> $stable(wbAdr) && $stable(wbWe) && $stable(wbDatO)
	) else $error("Wishbone outputs changed before ack");

endmodule

/* design/fetchDecode.sv */
`timescale 1ns/10ps

module fetchDecode import accPkg::*; (
	input  logic                 clr,
	input  logic                 rst,
	output logic [addrWidth-1:0] progAddr,
	input  instrWord_u           progData,
	input  logic                 halted,
	issueIf.source               issue
);

	// Program counter. The program port answers within the same cycle.
	logic [addrWidth-1:0] pc;

	// Class of the word now on progData.
	opClass_e fetchClass;

	// High while a HALT sits in execute. It is consumed in that same cycle.
	logic haltIssued;

	assign progAddr = pc;

	////////////////////////////////////////////////////////////////////////////
	// Decode
	////////////////////////////////////////////////////////////////////////////

	// The opcode sits in the same bits in both instruction forms, so the
	// ALU view is good enough for classification.
	always_comb begin
		case (progData.aluForm.opcode)
			LDI, ADD, SUB, AND, OR, XOR: fetchClass = aluOp;
			LD:                          fetchClass = loadOp;
			ST:                          fetchClass = storeOp;
			JMP:                         fetchClass = jumpOp;
			BZ, BNZ:                     fetchClass = branchOp;
			HALT:                        fetchClass = haltOp;
			default:                     fetchClass = nopOp;
		endcase
	end

	assign haltIssued = issue.valid && (issue.opClass == haltOp);

	////////////////////////////////////////////////////////////////////////////
	// Program counter and valid
	////////////////////////////////////////////////////////////////////////////

	// A flush wins over everything else. The word fetched behind a taken
	// branch is dropped, and fetch restarts at the target one cycle later.
	// While stall is high nothing moves, so the item in execute stays put.
	always_ff @(posedge clr) begin
		if (rst) begin
			pc          <= '0;
			issue.valid <= 1'b0;
		end else if (issue.flush) begin
			pc          <= issue.flushTarget;
			issue.valid <= 1'b0;
		end else if (!issue.stall) begin
			if (halted || haltIssued) begin
				// Nothing more is issued once HALT reaches execute.
				issue.valid <= 1'b0;
			end else begin
				pc          <= pc + 1'b1;
				issue.valid <= 1'b1;
			end
		end
	end

	// Word and class of the fetched instruction. They hold while stall is high.
	always_ff @(posedge clr) begin
		if (!issue.stall) begin
			issue.instr   <= progData;
			issue.opClass <= fetchClass;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////////////////////

	// Execute raises halted; from then on no new item may show up here.
	haltStopsIssue: assert property (
		@(posedge clr) disable iff (rst)
		halted |=> !issue.valid
	) else $error("issue valid seen after halt");

endmodule

/* design/resultStage.sv */
`timescale 1ns/10ps

module resultStage import accPkg::*; (
	input  logic                 clr,
	input  logic                 rst,
	resultIf.sink                res,
	output logic                 retireValid,
	output logic                 retireAcc,
	output logic [dataWidth-1:0] retireData
);

	// Accumulator file. Entry 0 is A, entry 1 is B.
	logic [dataWidth-1:0] accFile [2];

	////////////////////////////////////////////////////////////////////////////
	// Accumulators
	////////////////////////////////////////////////////////////////////////////

	// Both accumulators start from zero after reset.
	always_ff @(posedge clr) begin
		if (rst) begin
			accFile[0] <= '0;
			accFile[1] <= '0;
		end else if (res.wrEn) begin
			accFile[res.wrAcc] <= res.wrData;
		end
	end

	// Execute sees the new value in the cycle after the write.
	assign res.accA = accFile[0];
	assign res.accB = accFile[1];

	////////////////////////////////////////////////////////////////////////////
	// Retire trace
	////////////////////////////////////////////////////////////////////////////

	// One pulse per write, one cycle after it. Together with the data this
	// gives the testbench the full order of architectural updates.
	always_ff @(posedge clr) begin
		if (rst) begin
			retireValid <= 1'b0;
		end else begin
			retireValid <= res.wrEn;
		end
	end

	// Accumulator index and value of the last write.
	always_ff @(posedge clr) begin
		if (res.wrEn) begin
			retireAcc  <= res.wrAcc;
			retireData <= res.wrData;
		end
	end

endmodule

/* run.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it from the project root.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f verilog.f --top-module accCoreTb \
	-Mdir obj_dir -o accCoreSim; then
	echo "Verilator build failed"
	exit 1
fi

if ! ./obj_dir/accCoreSim > sim.log 2>&1; then
	cat sim.log
	echo "simulation exited with an error status"
	exit 1
fi

cat sim.log

if grep -q "TESTS FAILED" sim.log; then
	exit 1
fi
exit 0

/* verification/accCoreTb.sv */
`timescale 1ns/10ps

module accCoreTb import accPkg::*; ();

	logic                  clr;
	logic                  rst;
	logic [addrWidth-1:0]  progAddr;
	logic [instrWidth-1:0] progData;
	logic                  wbCyc;
	logic                  wbStb;
	logic                  wbWe;
	logic [addrWidth-1:0]  wbAdr;
	logic [dataWidth-1:0]  wbDatO;
	logic [dataWidth-1:0]  wbDatI;
	logic                  wbAck;
	logic                  halted;
	logic                  retireValid;
	logic                  retireAcc;
	logic [dataWidth-1:0]  retireData;

	// Program and data memory images, and the expected traffic in order.
	logic [instrWidth-1:0] progMem [256];
	logic [dataWidth-1:0]  dataMem [256];
	logic [15:0]           storeQ [$];
	logic [8:0]            retireQ [$];

	int          progWords = 0;
	int          expStores = 0;
	int          expRetires = 0;
	int          storesSeen = 0;
	int          retiresSeen = 0;
	int          errors = 0;
	int          cycles = 0;
	int          haltCycles = 0;
	int          limit;
	int          ackCount = 0;
	logic        ackWaiting = 1'b0;
	logic        nextAck;
	logic        done = 1'b0;
	logic [31:0] lfsr = 32'h6d59_129b;

	clockGen clockGen_i (
		.clr (clr),
		.rst (rst)
	);

	accCore dut_i (
		.clr         (clr),
		.rst         (rst),
		.progAddr    (progAddr),
		.progData    (progData),
		.wbCyc       (wbCyc),
		.wbStb       (wbStb),
		.wbWe        (wbWe),
		.wbAdr       (wbAdr),
		.wbDatO      (wbDatO),
		.wbDatI      (wbDatI),
		.wbAck       (wbAck),
		.halted      (halted),
		.retireValid (retireValid),
		.retireAcc   (retireAcc),
		.retireData  (retireData)
	);

	// The program port is answered within the same cycle.
	assign progData = progMem[progAddr];

	////////////////////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////////////////////

	// Galois form of x^32 + x^22 + x^2 + x + 1, shifting right.
	function automatic logic [31:0] lfsrNext(input logic [31:0] state);
		return {1'b0, state[31:1]} ^ (state[0] ? 32'h8020_0003 : 32'h0);
	endfunction

	// Takes one LFSR bit per step, first bit ends up most significant.
	task automatic drawBits(input int count, output int value);
		value = 0;
		for (int i = 0; i < count; i++) begin
			value = value * 2 + int'(lfsr[0]);
			lfsr = lfsrNext(lfsr);
		end
	endtask

	task automatic reportMismatch(input string name, input logic [7:0] expected,
			input logic [7:0] actual);
		errors++;
		$display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
	endtask

	// Unlisted program words decode as HALT with the address in the low byte,
	// and unlisted data bytes are the address with a fixed XOR.
	task automatic loadGolden();
		int              fd;
		int              count;
		logic [7:0]      kind;
		logic [31:0]     first;
		logic [31:0]     second;
		logic [8*96-1:0] rest;
		for (int i = 0; i < 256; i++) begin
			progMem[i] = {4'hF, 4'h0, i[7:0]};
			dataMem[i] = i[7:0] ^ 8'h5A;
		end
		fd = $fopen("verification/golden_program.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("could not open verification/golden_program.txt");
		end else begin
			while ($fscanf(fd, "%s", kind) == 1) begin
				if (kind == "#") begin
					count = $fgets(rest, fd);
				end else begin
					count = $fscanf(fd, "%h %h", first, second);
					case (kind)
						"P": begin
							progMem[first[7:0]] = second[15:0];
							progWords++;
						end
						"L": dataMem[first[7:0]] = second[7:0];
						"S": storeQ.push_back({first[7:0], second[7:0]});
						"R": retireQ.push_back({first[0], second[7:0]});
						"N": begin
							expStores  = first;
							expRetires = second;
						end
						default: begin
							errors++;
							$display("golden file holds a line of unknown kind");
						end
					endcase
				end
			end
			$fclose(fd);
		end
	endtask

	// Retires must arrive one by one in the golden order.
	task automatic checkRetire();
		logic [8:0] expected;
		if (retireValid === 1'b1) begin
			retiresSeen++;
			if (retireQ.size() == 0) begin
				errors++;
				$display("retire seen but none expected (acc %0d, data %h)", retireAcc, retireData);
			end else begin
				expected = retireQ.pop_front();
				if (retireAcc !== expected[8])
					reportMismatch($sformatf("retire %0d acc", retiresSeen),
						{7'b0, expected[8]}, {7'b0, retireAcc});
				if (retireData !== expected[7:0])
					reportMismatch($sformatf("retire %0d data", retiresSeen),
						expected[7:0], retireData);
			end
		end
	endtask

	// Wishbone slave. The ack comes 1 to 4 cycles after the strobe rises,
	// and a transfer completes at the edge where ack is high.
	task automatic serveBus(output logic ackOut);
		logic [15:0] expected;
		int          delay;
		ackOut = 1'b0;
		// A strobe is only legal inside a bus cycle.
		if (wbStb === 1'b1 && wbCyc !== 1'b1) begin
			errors++;
			$display("strobe raised outside of a bus cycle");
		end
		if (wbAck) begin
			if (wbWe) begin
				storesSeen++;
				if (storeQ.size() == 0) begin
					errors++;
					$display("store seen but none expected (addr %h)", wbAdr);
				end else begin
					expected = storeQ.pop_front();
					if (wbAdr !== expected[15:8])
						reportMismatch("store addr", expected[15:8], wbAdr);
					if (wbDatO !== expected[7:0])
						reportMismatch("store data", expected[7:0], wbDatO);
				end
				dataMem[wbAdr] = wbDatO;
			end
		end else if (wbStb) begin
			if (!ackWaiting) begin
				drawBits(2, delay);
				ackCount   = delay + 1;
				ackWaiting = 1'b1;
			end
			ackCount--;
			if (ackCount == 0) begin
				ackOut     = 1'b1;
				ackWaiting = 1'b0;
			end
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////////////////////

	// Outputs are sampled at the rising edge, inputs change 1 ns later.
	initial begin
		wbAck  = 1'b0;
		wbDatI = '0;
		loadGolden();
		limit = progWords * 8 + 8 + 200;
		while (!done) begin
			@(posedge clr);
			cycles++;
			nextAck = 1'b0;
			if (rst) begin
				// The first edge is the one that applies reset.
				if (cycles > 1 &&
						(wbCyc !== 1'b0 || wbStb !== 1'b0 || retireValid !== 1'b0)) begin
					errors++;
					$display("bus cycle, strobe or retire active during reset");
				end
			end else begin
				checkRetire();
				serveBus(nextAck);
				if (halted === 1'b1) begin
					if (wbCyc !== 1'b0 || wbStb !== 1'b0 || retireValid !== 1'b0) begin
						errors++;
						$display("bus cycle, strobe or retire after halt");
					end
					haltCycles++;
					if (haltCycles > 20)
						done = 1'b1;
				end
			end
			if (!done && cycles >= limit) begin
				errors++;
				$display("timeout, halted did not rise within %0d cycles", limit);
				done = 1'b1;
			end
			#1;
			wbAck = nextAck;
			if (nextAck)
				wbDatI = dataMem[wbAdr];
		end
		if (storesSeen != expStores) begin
			errors++;
			$display("[FAIL] store count: expected %0d, actual %0d", expStores, storesSeen);
		end
		if (retiresSeen != expRetires) begin
			errors++;
			$display("[FAIL] retire count: expected %0d, actual %0d", expRetires, retiresSeen);
		end
		$display("errors %0d, stores %0d of %0d, retires %0d of %0d, cycles %0d",
			errors, storesSeen, expStores, retiresSeen, expRetires, cycles);
		if (errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

/* verification/clockGen.sv */
`timescale 1ns/10ps

module clockGen (
	output logic clr,
	output logic rst
);

	// Free-running clock with a 10 ns period.
	initial begin
		clr = 1'b0;
		forever #5 clr = ~clr;
	end

	// Reset covers the first eight rising edges. It drops 1 ns after the last
	// one, in step with the other inputs of the DUT.
	initial begin
		rst = 1'b1;
		repeat (8) @(posedge clr);
		#1 rst = 1'b0;
	end

endmodule

/* verification/golden_program.txt */
# Kind, then two hex columns: P addr word, L addr byte, S addr data,
# R acc value (0 is A, 1 is B), N stores retires. Text after # is ignored.
P 00 10F0 # LDI A, F0
P 01 2020 # ADD A, 20 wraps to 10
P 02 1805 # LDI B, 05
P 03 3400 # SUB A, B
P 04 4C00 # AND B, A
P 05 500C # OR A, 0C
P 06 68FF # XOR B, FF
P 07 7040 # LD A, [40]
P 08 2C00 # ADD B, A wraps to 3A
P 09 8850 # ST B, [50]
P 0A 7841 # LD B, [41]
P 0B 8851 # ST B, [51]
P 0C B80E # BNZ B, 0E taken
P 0D 10EE # marker, skipped
P 0E A81F # BZ B, 1F not taken
P 0F 38C5 # SUB B, C5 gives 00
P 10 A812 # BZ B, 12 taken
P 11 18EE # marker, skipped
P 12 9014 # JMP 14
P 13 10EE # marker, skipped
P 14 B016 # BNZ A, 16 taken
P 15 18EE # marker, skipped
P 16 F000 # HALT
L 40 3C
L 41 C5
S 50 3A
S 51 C5
R 0 F0
R 0 10
R 1 05
R 0 0B
R 1 01
R 0 0F
R 1 FE
R 0 3C
R 1 3A
R 1 C5
R 1 00
N 2 0B

/* verilog.f */
design/accPkg.sv
design/accIf.sv
design/fetchDecode.sv
design/executeStage.sv
design/resultStage.sv
design/accCore.sv
verification/clockGen.sv
verification/accCoreTb.sv
